/* source/fir_pkg.sv */
/*
 * shared widths, tap counts and pipeline latency for the symmetric FIR
 * sample, coefficient and vector types, and the coefficient table
 */
`default_nettype none

package fir_pkg;

	// ******************************
	// sizes
	// ******************************

	// sample width, also every internal word
	localparam int SAMPLE_W = 18;

	// full delay line depth
	localparam int NUM_TAPS = 24;

	// symmetric filter, so half the taps carry unique coefficients
	localparam int NUM_UNIQ = NUM_TAPS / 2;

	// tap line 1 + pair/mult 2 + adder tree 4
	localparam int PIPE_LATENCY = 7;

	// ******************************
	// types
	// ******************************

	// signed sample, pair sum, product and partial sum
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// signed coefficient
	typedef logic signed [SAMPLE_W-1:0] coeff_t;

	// delay line contents, index 0 is the newest sample
	typedef sample_t tap_vec_t [NUM_TAPS];

	// one word per unique coefficient
	typedef sample_t uniq_vec_t [NUM_UNIQ];

	// ******************************
	// coefficients
	// ******************************

	// first half of the impulse response, mirrored for taps 12..23
	localparam coeff_t COEFFS [NUM_UNIQ] = '{
		18'sd88,   18'sd0,    -18'sd97,  -18'sd197,
		-18'sd294, -18'sd380, -18'sd447, -18'sd490,
		-18'sd504, -18'sd481, -18'sd420, -18'sd319
	};

endpackage

`default_nettype wire

/* source/fir_tap_line.sv */
/*
 * sample delay line for the FIR
 * shifts one place per enabled edge, all taps exposed
 */
`timescale 1ns/1ps
`default_nettype none

module fir_tap_line
	import fir_pkg::*;
(
	input  wire     clk,
	input  wire     reset,
	input  wire     i_clk_ena,
	input  sample_t i_in,
	output tap_vec_t o_taps
);

	// ******************************
	// delay line registers
	// ******************************

	tap_vec_t taps_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			// taps not yet reached by a sample read as zero
			for (int k = 0; k < NUM_TAPS; k++) begin
				taps_q[k] <= '0;
			end
		end else if (i_clk_ena) begin
			// newest sample enters at tap 0
			taps_q[0] <= i_in;
			for (int k = 1; k < NUM_TAPS; k++) begin
				taps_q[k] <= taps_q[k-1];
			end
		end
	end

	// ******************************
	// outputs
	// ******************************

	// both ends go to the pair adders
	always_comb begin
		for (int k = 0; k < NUM_TAPS; k++) begin
			o_taps[k] = taps_q[k];
		end
	end

endmodule

`default_nettype wire

/* source/fir_pair_mult.sv */
/*
 * mirrored tap pair adders and coefficient multipliers
 * two register stages, all arithmetic wraps to the sample width
 */
`timescale 1ns/1ps
`default_nettype none

module fir_pair_mult
	import fir_pkg::*;
(
	input  wire       clk,
	input  wire       reset,
	input  wire       i_clk_ena,
	input  tap_vec_t  i_taps,
	output uniq_vec_t o_products
);

	// ******************************
	// stage 1, pair sums
	// ******************************

	// tap k paired with tap NUM_TAPS-1-k
	uniq_vec_t pair_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int k = 0; k < NUM_UNIQ; k++) begin
				pair_q[k] <= '0;
			end
		end else if (i_clk_ena) begin
			for (int k = 0; k < NUM_UNIQ; k++) begin
				// carry out of bit 17 is dropped
				pair_q[k] <= i_taps[k] + i_taps[NUM_TAPS-1-k];
			end
		end
	end

	// ******************************
	// stage 2, products
	// ******************************

	uniq_vec_t prod_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int k = 0; k < NUM_UNIQ; k++) begin
				prod_q[k] <= '0;
			end
		end else if (i_clk_ena) begin
			for (int k = 0; k < NUM_UNIQ; k++) begin
				// low 18 bits of the signed product, no rounding
				prod_q[k] <= sample_t'(pair_q[k] * COEFFS[k]);
			end
		end
	end

	// ******************************
	// outputs
	// ******************************

	always_comb begin
		for (int k = 0; k < NUM_UNIQ; k++) begin
			o_products[k] = prod_q[k];
		end
	end

endmodule

`default_nettype wire

/* source/fir_adder_tree.sv */
/*
 * registered reduction tree, 12 products down to one sum
 * levels 12 > 6 > 3 > 2 > 1, level 3 leftover goes through a bypass register
 */
`timescale 1ns/1ps
`default_nettype none

module fir_adder_tree
	import fir_pkg::*;
(
	input  wire       clk,
	input  wire       reset,
	input  wire       i_clk_ena,
	input  uniq_vec_t i_products,
	output sample_t   o_sum
);

	// ******************************
	// partial sum registers
	// ******************************

	// level 1, adjacent product pairs
	sample_t l1_q [NUM_UNIQ/2];

	// level 2, adjacent level 1 pairs
	sample_t l2_q [NUM_UNIQ/4];

	// level 3, one adder and the odd one out
	sample_t l3_sum_q;
	sample_t l3_byp_q;

	// level 4, the filter output
	sample_t l4_q;

	// ******************************
	// levels 1 and 2
	// ******************************

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int k = 0; k < NUM_UNIQ/2; k++) begin
				l1_q[k] <= '0;
			end
			for (int k = 0; k < NUM_UNIQ/4; k++) begin
				l2_q[k] <= '0;
			end
		end else if (i_clk_ena) begin
			for (int k = 0; k < NUM_UNIQ/2; k++) begin
				l1_q[k] <= i_products[2*k] + i_products[2*k+1];
			end
			for (int k = 0; k < NUM_UNIQ/4; k++) begin
				l2_q[k] <= l1_q[2*k] + l1_q[2*k+1];
			end
		end
	end

	// ******************************
	// levels 3 and 4
	// ******************************

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			l3_sum_q <= '0;
			l3_byp_q <= '0;
			l4_q     <= '0;
		end else if (i_clk_ena) begin
			l3_sum_q <= l2_q[0] + l2_q[1];
			// keeps the third partial sum in step with the adder path
			l3_byp_q <= l2_q[2];
			l4_q     <= l3_sum_q + l3_byp_q;
		end
	end

	assign o_sum = l4_q;

endmodule

`default_nettype wire

/* source/fir_valid_ctrl.sv */
/*
 * valid flag pipeline, as deep as the datapath
 */
`timescale 1ns/1ps
`default_nettype none

module fir_valid_ctrl
	import fir_pkg::*;
(
	input  wire  clk,
	input  wire  reset,
	input  wire  i_clk_ena,
	input  wire  i_valid,
	output logic o_valid
);

	// ******************************
	// flag shift register
	// ******************************

	// bit 0 is captured with the sample entering tap 0
	logic [PIPE_LATENCY-1:0] vld_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			vld_q <= '0;
		end else if (i_clk_ena) begin
			// advances only with the datapath
			vld_q <= {vld_q[PIPE_LATENCY-2:0], i_valid};
		end
	end

	// lines up with the adder tree output register
	assign o_valid = vld_q[PIPE_LATENCY-1];

endmodule

`default_nettype wire

/* source/fir_top.sv */
/*
 * 24 tap symmetric FIR filter, top level
 * tap line, pair adders and multipliers, adder tree, valid pipeline
 */
`timescale 1ns/1ps
`default_nettype none

module fir_top
	import fir_pkg::*;
(
	input  wire     clk,
	input  wire     reset,
	input  wire     i_clk_ena,
	input  wire     i_valid,
	input  sample_t i_in,
	output logic    o_valid,
	output sample_t o_out
);

	// ******************************
	// internal buses
	// ******************************

	// delay line contents
	tap_vec_t taps;

	// registered coefficient products
	uniq_vec_t products;

	// ******************************
	// datapath
	// ******************************

	// 1 edge, sample into tap 0
	fir_tap_line u_tap_line (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_in      (i_in),
		.o_taps    (taps)
	);

	// 2 edges, pair sums then products
	fir_pair_mult u_pair_mult (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (i_clk_ena),
		.i_taps     (taps),
		.o_products (products)
	);

	// 4 edges, last level is the output register
	fir_adder_tree u_adder_tree (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (i_clk_ena),
		.i_products (products),
		.o_sum      (o_out)
	);

	// ******************************
	// control
	// ******************************

	// valid flag follows the sample through all 7 stages
	fir_valid_ctrl u_valid_ctrl (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.o_valid   (o_valid)
	);

endmodule

`default_nettype wire

/* testbench/fir_chk.sv */
/*
 * concurrent assertions on the FIR top level ports
 * reset values, hold while disabled, valid alignment
 */
`timescale 1ns/1ps
`default_nettype none

module fir_chk
	import fir_pkg::*;
(
	input wire     clk,
	input wire     reset,
	input wire     i_clk_ena,
	input wire     i_valid,
	input wire     o_valid,
	input sample_t o_out
);

	// failed assertion count, read by the testbench at the end
	int fail_count = 0;

	// ******************************
	// port properties
	// ******************************

	// outputs cleared while reset is high
	reset_clears_outputs: assert property (@(posedge clk)
		reset |-> (o_valid == 1'b0 && o_out == '0))
		else begin
			$error("outputs not zero during reset");
			fail_count++;
		end

	// nothing moves on a disabled edge
	disabled_edge_holds: assert property (@(posedge clk) disable iff (reset)
		!i_clk_ena |=> ($stable(o_out) && $stable(o_valid)))
		else begin
			$error("outputs changed on a disabled clock edge");
			fail_count++;
		end

	// only checked when the enable stayed high the whole way
	valid_alignment: assert property (@(posedge clk) disable iff (reset)
		i_clk_ena [*PIPE_LATENCY] |=> (o_valid == $past(i_valid, PIPE_LATENCY)))
		else begin
			$error("o_valid does not follow i_valid by the pipeline latency");
			fail_count++;
		end

endmodule

bind fir_top fir_chk u_chk (
	.clk       (clk),
	.reset     (reset),
	.i_clk_ena (i_clk_ena),
	.i_valid   (i_valid),
	.o_valid   (o_valid),
	.o_out     (o_out)
);

`default_nettype wire

/* testbench/fir_model.svh */
/*
 * software model of the symmetric FIR for the testbench
 * tap copy, output rule, expected output queue, xorshift generator
 */
`ifndef FIR_MODEL_SVH
`define FIR_MODEL_SVH

// software copy of the delay line, index 0 newest
sample_t model_taps [NUM_TAPS];

// expected outputs, one per enabled edge, with their valid flags
sample_t exp_out_q [$];
logic    exp_vld_q [$];

logic [31:0] rng_state;

// 32 bit xorshift, shifts 13 17 5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

function automatic logic [31:0] next_rand();
	rng_state = xorshift32(rng_state);
	return rng_state;
endfunction

// y = sum of coeff k times (tap k + tap 23-k), low 18 bits kept
function automatic sample_t model_output();
	longint acc;
	acc = 0;
	for (int k = 0; k < NUM_UNIQ; k++) begin
		acc += longint'(COEFFS[k]) *
			(longint'(model_taps[k]) + longint'(model_taps[NUM_TAPS-1-k]));
	end
	return sample_t'(acc[SAMPLE_W-1:0]);
endfunction

// cleared taps, and the zero outputs already inside the pipeline
task automatic model_reset();
	for (int k = 0; k < NUM_TAPS; k++) begin
		model_taps[k] = '0;
	end
	exp_out_q.delete();
	exp_vld_q.delete();
	for (int k = 0; k < PIPE_LATENCY - 1; k++) begin
		exp_out_q.push_back('0);
		exp_vld_q.push_back(1'b0);
	end
endtask

// one enabled edge, the result leaves the queue PIPE_LATENCY edges later
task automatic model_step(input sample_t x, input logic v);
	for (int k = NUM_TAPS - 1; k > 0; k--) begin
		model_taps[k] = model_taps[k-1];
	end
	model_taps[0] = x;
	exp_out_q.push_back(model_output());
	exp_vld_q.push_back(v);
endtask

`endif

/* testbench/fir_tb.sv */
/*
 * testbench for the symmetric FIR top level
 * clock and reset, directed tests against the software model, result counts
 */
`timescale 1ns/1ps
`default_nettype none

module fir_tb
	import fir_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int DRIVE_DELAY = 2;
	localparam int VALID_TIMEOUT = 50;
	localparam logic [31:0] RNG_SEED = 32'd39539;

	logic    clk;
	logic    reset;
	logic    i_clk_ena;
	logic    i_valid;
	sample_t i_in;
	logic    o_valid;
	sample_t o_out;

	int errors;
	int tests_run;
	int tests_failed;
	int test_err_start;
	int valid_seen;

	`include "fir_model.svh"

	fir_top i_dut (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_in      (i_in),
		.o_valid   (o_valid),
		.o_out     (o_out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// ******************************
	// check helpers
	// ******************************

	task automatic check_value(input string what, input sample_t got, input sample_t exp);
		assert (got === exp) else begin
			$display("ERROR at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("ERROR at %0d ns: %s got %b expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		assert (got == exp) else begin
			$display("ERROR at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	function automatic int rand_below(input int n);
		return int'(next_rand() % n);
	endfunction

	function automatic sample_t rand_sample();
		return sample_t'(next_rand());
	endfunction

	function automatic logic pending_valid();
		foreach (exp_vld_q[i]) begin
			if (exp_vld_q[i]) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	// impulse response reads the coefficients forward then mirrored
	function automatic sample_t impulse_coeff(input int k);
		if (k < NUM_UNIQ) begin
			return COEFFS[k];
		end
		return COEFFS[NUM_TAPS-1-k];
	endfunction

	// ******************************
	// drive one clock edge
	// ******************************

	// called just after an edge and returns just after the next one
	task automatic apply_edge(input logic en, input logic v, input sample_t x);
		sample_t held_out;
		logic    held_vld;
		sample_t exp_out;
		logic    exp_vld;
		held_out = o_out;
		held_vld = o_valid;
		i_clk_ena = en;
		i_valid = v;
		i_in = x;
		@(posedge clk);
		#DRIVE_DELAY;
		if (en) begin
			model_step(x, v);
			exp_out = exp_out_q.pop_front();
			exp_vld = exp_vld_q.pop_front();
			check_flag("o_valid", o_valid, exp_vld);
			check_value("o_out", o_out, exp_out);
			if (o_valid === 1'b1) begin
				valid_seen++;
			end
		end else begin
			check_flag("o_valid during stall", o_valid, held_vld);
			check_value("o_out during stall", o_out, held_out);
		end
	endtask

	// run zeros until every flagged sample has come out
	task automatic drain_pipeline(input string name);
		int cnt;
		cnt = 0;
		while (pending_valid() && cnt < VALID_TIMEOUT) begin
			apply_edge(1'b1, 1'b0, '0);
			cnt++;
		end
		assert (!pending_valid()) else begin
			$display("%s: timed out waiting for the last valid outputs", name);
			errors++;
		end
	endtask

	task automatic reset_dut();
		#DRIVE_DELAY;
		reset = 1'b1;
		i_clk_ena = 1'b0;
		i_valid = 1'b0;
		i_in = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		model_reset();
	endtask

	task automatic end_test(input string name);
		int n;
		n = errors - test_err_start;
		tests_run++;
		if (n == 0) begin
			$display("%s: pass", name);
		end else begin
			tests_failed++;
			$display("%s: FAIL with %0d errors", name, n);
		end
		test_err_start = errors;
	endtask

	// ******************************
	// tests
	// ******************************

	task automatic test_reset_state();
		for (int k = 0; k < 40; k++) begin
			apply_edge(1'b1, 1'b0, '0);
			check_flag("o_valid after reset", o_valid, 1'b0);
			check_value("o_out after reset", o_out, '0);
		end
		end_test("reset state");
	endtask

	task automatic test_impulse();
		int wait_cnt;
		int pulses;
		// flush the delay line
		for (int k = 0; k < NUM_TAPS; k++) begin
			apply_edge(1'b1, 1'b0, '0);
		end
		apply_edge(1'b1, 1'b1, 18'sd1);
		wait_cnt = 1;
		while (o_valid !== 1'b1 && wait_cnt < VALID_TIMEOUT) begin
			apply_edge(1'b1, 1'b0, '0);
			wait_cnt++;
		end
		assert (o_valid === 1'b1) else begin
			$display("impulse: o_valid never rose after the impulse");
			errors++;
		end
		if (o_valid === 1'b1) begin
			check_count("impulse latency", wait_cnt, PIPE_LATENCY);
			pulses = 0;
			for (int k = 0; k < NUM_TAPS; k++) begin
				if (k > 0) begin
					apply_edge(1'b1, 1'b0, '0);
				end
				if (o_valid === 1'b1) begin
					pulses++;
				end
				check_value("impulse response", o_out, impulse_coeff(k));
			end
			check_count("impulse valid pulses", pulses, 1);
		end
		drain_pipeline("impulse");
		end_test("impulse response");
	endtask

	task automatic test_random_stream();
		int seen_start;
		sample_t x;
		seen_start = valid_seen;
		for (int k = 0; k < 200; k++) begin
			x = rand_sample();
			// full scale now and then to force wraparound
			if (k % 20 == 5) begin
				x = 18'sh1ffff;
			end else if (k % 20 == 15) begin
				x = 18'sh20000;
			end
			apply_edge(1'b1, 1'b1, x);
		end
		drain_pipeline("random stream");
		check_count("random stream valid outputs", valid_seen - seen_start, 200);
		end_test("random stream");
	endtask

	task automatic test_clock_stall();
		int seen_start;
		int gap;
		seen_start = valid_seen;
		for (int k = 0; k < 150; k++) begin
			if (rand_below(6) == 0) begin
				gap = 1 + rand_below(5);
				// inputs toggle while disabled and must be ignored
				repeat (gap) apply_edge(1'b0, rand_below(2) == 1, rand_sample());
			end
			apply_edge(1'b1, 1'b1, rand_sample());
		end
		drain_pipeline("clock stall");
		check_count("stalled stream valid outputs", valid_seen - seen_start, 150);
		end_test("clock enable stall");
	endtask

	task automatic test_valid_gaps();
		int seen_start;
		int driven;
		logic v;
		seen_start = valid_seen;
		driven = 0;
		for (int k = 0; k < 200; k++) begin
			v = (rand_below(3) != 0);
			if (v) begin
				driven++;
			end
			apply_edge(1'b1, v, rand_sample());
		end
		drain_pipeline("valid gaps");
		check_count("gapped stream valid outputs", valid_seen - seen_start, driven);
		end_test("valid gaps");
	endtask

	// ******************************
	// main sequence
	// ******************************

	initial begin
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_err_start = 0;
		valid_seen = 0;
		rng_state = RNG_SEED;
		reset = 1'b0;
		i_clk_ena = 1'b0;
		i_valid = 1'b0;
		i_in = '0;
		reset_dut();
		test_reset_state();
		test_impulse();
		test_random_stream();
		test_clock_stall();
		test_valid_gaps();
		$display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, i_dut.u_chk.fail_count);
		if (errors == 0 && tests_failed == 0 && i_dut.u_chk.fail_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+testbench
source/fir_pkg.sv
source/fir_tap_line.sv
source/fir_pair_mult.sv
source/fir_adder_tree.sv
source/fir_valid_ctrl.sv
source/fir_top.sv
testbench/fir_chk.sv
testbench/fir_tb.sv
